/* hdl/acc_types_pkg.sv */
// Accumulator types
// Data widths, epoch tags and scheduler states of the rescaling accumulator
package acc_types_pkg;

    // Data and accumulator width
    parameter int unsigned ACC_W = 32;

    // Pipeline depth, which also bounds the partials in flight
    parameter int unsigned MAC_STAGES = 4;

    parameter int unsigned FIFO_DEPTH = 8;

    // Factor epoch tag width
    parameter int unsigned TAG_W = 4;

    typedef logic [ACC_W-1:0] acc_data_t;
    typedef logic [TAG_W-1:0] acc_tag_t;

    typedef enum logic [1:0] {
        ACCUMULATE,
        DRAIN,
        REDUCE,
        DONE
    } sched_state_e;

endpackage

/* hdl/acc_regs_pkg.sv */
// Accumulator register map
// AXI4-Lite offsets and response codes of the control block
package acc_regs_pkg;

    parameter int unsigned AXIL_ADDR_W = 4;

    // Write-only pulses: bit 0 clear, bit 1 finish
    parameter logic [AXIL_ADDR_W-1:0] REG_CTRL = 4'h0;
    // Bit 0 busy, bit 1 done
    parameter logic [AXIL_ADDR_W-1:0] REG_STATUS = 4'h4;
    parameter logic [AXIL_ADDR_W-1:0] REG_RESULT = 4'h8;
    // Addends accepted since the last clear
    parameter logic [AXIL_ADDR_W-1:0] REG_COUNT = 4'hC;

    typedef logic [1:0] axil_resp_t;

    parameter axil_resp_t RESP_OKAY = 2'b00;
    parameter axil_resp_t RESP_SLVERR = 2'b10;

endpackage

/* hdl/tagged_fifo.sv */
// Tagged FIFO
// Circular buffer holding a data word and its factor epoch tag
`timescale 1ns/1ps

module tagged_fifo #(
    parameter int unsigned DATA_W = 32,
    parameter int unsigned DEPTH = 8
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     push_i,
    input  logic [DATA_W-1:0]        data_i,
    input  acc_types_pkg::acc_tag_t  tag_i,
    input  logic                     pop_i,
    output logic [DATA_W-1:0]        data_o,
    output acc_types_pkg::acc_tag_t  tag_o,
    output logic                     empty_o,
    output logic                     full_o
);
    import acc_types_pkg::*;

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_W-1:0] data_mem [DEPTH];
    acc_tag_t          tag_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]    count_q;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
    assign data_o  = data_mem[rd_ptr_q];
    assign tag_o   = tag_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            data_mem[wr_ptr_q] <= data_i;
            tag_mem[wr_ptr_q]  <= tag_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_i);
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(push_i && full_o));
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_i && empty_o));

endmodule

/* hdl/rescale_mac_pipe.sv */
// Rescaling multiply-add pipeline
// Computes a * b + c with a fixed latency and carries a tag beside each operation
`timescale 1ns/1ps

module rescale_mac_pipe #(
    parameter int unsigned DATA_W = 32,
    parameter int unsigned STAGES = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     valid_i,
    input  logic [DATA_W-1:0]        a_i,
    input  logic [DATA_W-1:0]        b_i,
    input  acc_types_pkg::acc_data_t c_i,
    input  acc_types_pkg::acc_tag_t  tag_i,
    output logic                     valid_o,
    output logic [DATA_W-1:0]        res_o,
    output acc_types_pkg::acc_tag_t  tag_o
);
    import acc_types_pkg::*;

    logic [STAGES-1:0] valid_q;
    logic [DATA_W-1:0] data_q [STAGES];
    acc_tag_t          tag_q [STAGES];

    // Valid bits carry the control state of the chain
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[STAGES-2:0], valid_i};
        end
    end

    // Product is formed at the first stage, later stages only delay it
    always_ff @(posedge clk_i) begin
        data_q[0] <= a_i * b_i + DATA_W'(c_i);
        tag_q[0]  <= tag_i;
        for (int i = 1; i < STAGES; i++) begin
            data_q[i] <= data_q[i-1];
            tag_q[i]  <= tag_q[i-1];
        end
    end

    assign valid_o = valid_q[STAGES-1];
    assign res_o   = data_q[STAGES-1];
    assign tag_o   = tag_q[STAGES-1];

endmodule

/* hdl/partial_sum_sched.sv */
// Partial sum scheduler
// Tags, factor use counting, operand choice for the pipeline and final reduction
`timescale 1ns/1ps

module partial_sum_sched #(
    parameter int unsigned DATA_W = 32,
    parameter int unsigned STAGES = 4,
    parameter int unsigned DEPTH = 8
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    clear_i,
    input  logic                    finish_i,
    input  logic                    mul_push_i,
    input  logic [DATA_W-1:0]       add_data_i,
    input  acc_types_pkg::acc_tag_t add_tag_i,
    input  logic                    add_empty_i,
    input  logic [DATA_W-1:0]       mul_data_i,
    input  acc_types_pkg::acc_tag_t mul_tag_i,
    input  logic                    mul_empty_i,
    input  logic                    pipe_valid_i,
    input  logic [DATA_W-1:0]       pipe_res_i,
    input  acc_types_pkg::acc_tag_t pipe_tag_i,
    output logic                    add_pop_o,
    output logic                    mul_pop_o,
    output acc_types_pkg::acc_tag_t tag_cnt_o,
    output logic                    issue_valid_o,
    output logic [DATA_W-1:0]       a_o,
    output logic [DATA_W-1:0]       b_o,
    output logic [DATA_W-1:0]       c_o,
    output acc_types_pkg::acc_tag_t issue_tag_o,
    output logic                    accept_o,
    output logic [DATA_W-1:0]       count_o,
    output logic                    busy_o,
    output logic                    done_o,
    output logic [DATA_W-1:0]       result_o
);
    import acc_types_pkg::*;

    localparam int unsigned CNT_W = $clog2(STAGES + 1);

    sched_state_e state_q;
    acc_tag_t     tag_cnt_q, ptag, next_tag;
    logic [CNT_W-1:0] inflight_q, uses_q;
    logic [DATA_W-1:0] count_q, result_q;
    logic done_q, run, last_use;
    logic add_hit, do_scale, add_after, do_start, do_skip;

    assign run = (state_q == ACCUMULATE) || (state_q == DRAIN);

    // Epoch of the oldest partials, equal to the head factor tag when one waits
    assign ptag     = mul_empty_i ? tag_cnt_q : mul_tag_i;
    assign next_tag = pipe_tag_i + 1'b1;
    assign last_use = (uses_q + 1'b1) == inflight_q;

    // An addend of the same epoch is merged before the factor is applied
    assign add_hit   = pipe_valid_i && !add_empty_i && (add_tag_i == pipe_tag_i);
    assign do_scale  = pipe_valid_i && !mul_empty_i && (pipe_tag_i == mul_tag_i) && !add_hit;
    assign add_after = do_scale && !add_empty_i && (add_tag_i == next_tag);
    // New partials only start in a bubble and never while a factor is half applied
    assign do_start  = !pipe_valid_i && !add_empty_i && (add_tag_i == ptag)
                       && (uses_q == '0) && (inflight_q < CNT_W'(STAGES));
    // No partial needs this factor
    assign do_skip   = !pipe_valid_i && (inflight_q == '0) && !mul_empty_i
                       && (add_empty_i || (add_tag_i != mul_tag_i));

    assign add_pop_o = run && (add_hit || add_after || do_start);
    assign mul_pop_o = run && ((do_scale && last_use) || do_skip);

    assign issue_valid_o = run && (pipe_valid_i || do_start);
    assign a_o = pipe_valid_i ? pipe_res_i : add_data_i;
    assign b_o = do_scale ? mul_data_i : DATA_W'(1);
    assign c_o = (add_hit || add_after) ? add_data_i : '0;
    assign issue_tag_o = !pipe_valid_i ? add_tag_i : (do_scale ? next_tag : pipe_tag_i);

    assign tag_cnt_o = tag_cnt_q;
    assign accept_o  = (state_q == ACCUMULATE);
    assign count_o   = count_q;
    assign busy_o    = (state_q != DONE);
    assign done_o    = done_q;
    assign result_o  = result_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= DONE;
            done_q     <= 1'b0;
            tag_cnt_q  <= '0;
            inflight_q <= '0;
            uses_q     <= '0;
            count_q    <= '0;
            result_q   <= '0;
        end else if (clear_i) begin
            state_q    <= ACCUMULATE;
            done_q     <= 1'b0;
            tag_cnt_q  <= '0;
            inflight_q <= '0;
            uses_q     <= '0;
            count_q    <= '0;
            result_q   <= '0;
        end else begin
            if (mul_push_i) begin
                tag_cnt_q <= tag_cnt_q + 1'b1;
            end
            if (add_pop_o) begin
                count_q <= count_q + 1'b1;
            end
            if (run && do_scale) begin
                uses_q <= last_use ? '0 : uses_q + 1'b1;
            end
            if (run && do_start) begin
                inflight_q <= inflight_q + 1'b1;
            end
            case (state_q)
                ACCUMULATE: if (finish_i) state_q <= DRAIN;
                DRAIN:      if (add_empty_i && mul_empty_i) state_q <= REDUCE;
                REDUCE: begin
                    if (pipe_valid_i) begin
                        result_q   <= result_q + pipe_res_i;
                        inflight_q <= inflight_q - 1'b1;
                    end else if (inflight_q == '0) begin
                        state_q <= DONE;
                        done_q  <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    a_inflight_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        inflight_q <= CNT_W'(STAGES));

endmodule

/* hdl/acc_axil_regs.sv */
// Accumulator control registers
// AXI4-Lite slave that pulses clear and finish and reports status, result and count
`timescale 1ns/1ps

module acc_axil_regs (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 s_awvalid_i,
    input  logic [acc_regs_pkg::AXIL_ADDR_W-1:0] s_awaddr_i,
    input  logic                                 s_wvalid_i,
    input  acc_types_pkg::acc_data_t             s_wdata_i,
    input  logic                                 s_bready_i,
    input  logic                                 s_arvalid_i,
    input  logic [acc_regs_pkg::AXIL_ADDR_W-1:0] s_araddr_i,
    input  logic                                 s_rready_i,
    input  logic                                 busy_i,
    input  logic                                 done_i,
    input  acc_types_pkg::acc_data_t             result_i,
    input  acc_types_pkg::acc_data_t             count_i,
    output logic                                 s_awready_o,
    output logic                                 s_wready_o,
    output logic                                 s_bvalid_o,
    output acc_regs_pkg::axil_resp_t             s_bresp_o,
    output logic                                 s_arready_o,
    output logic                                 s_rvalid_o,
    output acc_types_pkg::acc_data_t             s_rdata_o,
    output acc_regs_pkg::axil_resp_t             s_rresp_o,
    output logic                                 clear_o,
    output logic                                 finish_o
);
    import acc_regs_pkg::*;

    logic wr_fire, rd_fire, ctrl_hit;

    // Address and data are taken together, one write outstanding at a time
    assign s_awready_o = !s_bvalid_o && s_awvalid_i && s_wvalid_i;
    assign s_wready_o  = s_awready_o;
    assign wr_fire     = s_awready_o;
    assign ctrl_hit    = (s_awaddr_i == REG_CTRL);

    assign s_arready_o = !s_rvalid_o;
    assign rd_fire     = s_arvalid_i && s_arready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s_bvalid_o <= 1'b0;
            s_rvalid_o <= 1'b0;
            clear_o    <= 1'b0;
            finish_o   <= 1'b0;
        end else begin
            clear_o  <= wr_fire && ctrl_hit && s_wdata_i[0];
            finish_o <= wr_fire && ctrl_hit && s_wdata_i[1];
            if (wr_fire) begin
                s_bvalid_o <= 1'b1;
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
            if (rd_fire) begin
                s_rvalid_o <= 1'b1;
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            s_bresp_o <= ctrl_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            s_rresp_o <= RESP_OKAY;
            case (s_araddr_i)
                REG_CTRL:   s_rdata_o <= '0;
                REG_STATUS: s_rdata_o <= {{($bits(s_rdata_o) - 2){1'b0}}, done_i, busy_i};
                REG_RESULT: s_rdata_o <= result_i;
                REG_COUNT:  s_rdata_o <= count_i;
                default: begin
                    s_rdata_o <= '0;
                    s_rresp_o <= RESP_SLVERR;
                end
            endcase
        end
    end

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o);
    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

/* hdl/rescale_acc_top.sv */
// Rescaling accumulator top level
// Joins the register block, the tagged FIFOs, the scheduler and the pipeline
`timescale 1ns/1ps

module rescale_acc_top #(
    parameter int unsigned DATA_W = acc_types_pkg::ACC_W,
    parameter int unsigned STAGES = acc_types_pkg::MAC_STAGES,
    parameter int unsigned DEPTH = acc_types_pkg::FIFO_DEPTH
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 s_awvalid_i,
    input  logic [acc_regs_pkg::AXIL_ADDR_W-1:0] s_awaddr_i,
    output logic                                 s_awready_o,
    input  logic                                 s_wvalid_i,
    input  acc_types_pkg::acc_data_t             s_wdata_i,
    output logic                                 s_wready_o,
    output logic                                 s_bvalid_o,
    output acc_regs_pkg::axil_resp_t             s_bresp_o,
    input  logic                                 s_bready_i,
    input  logic                                 s_arvalid_i,
    input  logic [acc_regs_pkg::AXIL_ADDR_W-1:0] s_araddr_i,
    output logic                                 s_arready_o,
    output logic                                 s_rvalid_o,
    output acc_types_pkg::acc_data_t             s_rdata_o,
    output acc_regs_pkg::axil_resp_t             s_rresp_o,
    input  logic                                 s_rready_i,
    input  logic                                 add_valid_i,
    input  logic [DATA_W-1:0]                    add_data_i,
    input  logic                                 mul_valid_i,
    input  logic [DATA_W-1:0]                    mul_data_i,
    output logic                                 ready_o
);
    import acc_types_pkg::*;

    logic clear, finish, busy, done, accept;
    logic add_push, add_pop, add_empty, add_full;
    logic mul_push, mul_pop, mul_empty, mul_full;
    logic issue_valid, pipe_valid;
    logic [DATA_W-1:0] add_head, mul_head, op_a, op_b, op_c, pipe_res, result, count;
    acc_tag_t tag_cnt, add_tag_in, add_tag, mul_tag, issue_tag, pipe_tag;

    assign ready_o    = accept && !add_full && !mul_full;
    assign add_push   = add_valid_i && ready_o;
    assign mul_push   = mul_valid_i && ready_o;
    // A factor in the same cycle is ordered before the addend
    assign add_tag_in = tag_cnt + acc_tag_t'(mul_push);

    acc_axil_regs u_regs (
        .clk_i, .rst_ni,
        .s_awvalid_i, .s_awaddr_i, .s_wvalid_i, .s_wdata_i, .s_bready_i,
        .s_arvalid_i, .s_araddr_i, .s_rready_i,
        .busy_i(busy), .done_i(done), .result_i(result), .count_i(count),
        .s_awready_o, .s_wready_o, .s_bvalid_o, .s_bresp_o,
        .s_arready_o, .s_rvalid_o, .s_rdata_o, .s_rresp_o,
        .clear_o(clear), .finish_o(finish)
    );

    tagged_fifo #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_add_fifo (
        .clk_i, .rst_ni, .flush_i(clear), .push_i(add_push), .data_i(add_data_i),
        .tag_i(add_tag_in), .pop_i(add_pop), .data_o(add_head), .tag_o(add_tag),
        .empty_o(add_empty), .full_o(add_full)
    );

    tagged_fifo #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_mul_fifo (
        .clk_i, .rst_ni, .flush_i(clear), .push_i(mul_push), .data_i(mul_data_i),
        .tag_i(tag_cnt), .pop_i(mul_pop), .data_o(mul_head), .tag_o(mul_tag),
        .empty_o(mul_empty), .full_o(mul_full)
    );

    partial_sum_sched #(.DATA_W(DATA_W), .STAGES(STAGES), .DEPTH(DEPTH)) u_sched (
        .clk_i, .rst_ni, .clear_i(clear), .finish_i(finish), .mul_push_i(mul_push),
        .add_data_i(add_head), .add_tag_i(add_tag), .add_empty_i(add_empty),
        .mul_data_i(mul_head), .mul_tag_i(mul_tag), .mul_empty_i(mul_empty),
        .pipe_valid_i(pipe_valid), .pipe_res_i(pipe_res), .pipe_tag_i(pipe_tag),
        .add_pop_o(add_pop), .mul_pop_o(mul_pop), .tag_cnt_o(tag_cnt),
        .issue_valid_o(issue_valid), .a_o(op_a), .b_o(op_b), .c_o(op_c),
        .issue_tag_o(issue_tag), .accept_o(accept), .count_o(count),
        .busy_o(busy), .done_o(done), .result_o(result)
    );

    rescale_mac_pipe #(.DATA_W(DATA_W), .STAGES(STAGES)) u_mac (
        .clk_i, .rst_ni, .flush_i(clear), .valid_i(issue_valid),
        .a_i(op_a), .b_i(op_b), .c_i(op_c), .tag_i(issue_tag),
        .valid_o(pipe_valid), .res_o(pipe_res), .tag_o(pipe_tag)
    );

endmodule

/* verif/rescale_acc_tb.sv */
// Rescaling accumulator testbench
// Drives AXI4-Lite control and both streams, folds the accepted beats in a model
`timescale 1ns/1ps

module rescale_acc_tb;
    import acc_types_pkg::*;
    import acc_regs_pkg::*;

    // About 6 tests of up to 60 beats plus drains and polling, with a wide margin
    localparam int unsigned TIMEOUT_CYCLES = 3000;

    logic clk_i, rst_ni;
    logic s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
    logic [AXIL_ADDR_W-1:0] s_awaddr_i, s_araddr_i;
    logic s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
    acc_data_t s_wdata_i, s_rdata_o;
    axil_resp_t s_bresp_o, s_rresp_o;
    logic add_valid_i, mul_valid_i, ready_o;
    acc_data_t add_data_i, mul_data_i;

    acc_data_t model_acc, model_count, chk_exp, chk_act;
    logic cleared, saw_ready_low, chk_en;
    string chk_name, test_name;
    int errors, checks, tests, test_err_start;
    int unsigned cycles;

    rescale_acc_top u_rescale_acc_top (.*);

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: no result after %0d cycles, run stopped", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    a_value_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
        chk_en |-> (chk_act == chk_exp))
        else begin
            $display("FAILED %s: expected %h, actual %h", chk_name, chk_exp, chk_act);
            errors++;
        end

    a_ready_before_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !cleared |-> !ready_o)
        else begin
            $display("FAILED reset: ready_o expected 0, actual 1");
            errors++;
        end

    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input acc_data_t data,
                              output axil_resp_t resp);
        s_awvalid_i <= 1'b1;
        s_awaddr_i  <= addr;
        s_wvalid_i  <= 1'b1;
        s_wdata_i   <= data;
        do @(posedge clk_i); while (!(s_awready_o && s_wready_o));
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        do @(posedge clk_i); while (!s_bvalid_o);
        resp = s_bresp_o;
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output acc_data_t data,
                             output axil_resp_t resp);
        s_arvalid_i <= 1'b1;
        s_araddr_i  <= addr;
        do @(posedge clk_i); while (!s_arready_o);
        s_arvalid_i <= 1'b0;
        do @(posedge clk_i); while (!s_rvalid_o);
        data = s_rdata_o;
        resp = s_rresp_o;
    endtask

    // Values stay put for a full cycle so the failure line shows them
    task automatic check_value(input acc_data_t exp, input acc_data_t act);
        chk_name <= test_name;
        chk_exp  <= exp;
        chk_act  <= act;
        chk_en   <= 1'b1;
        checks++;
        @(posedge clk_i);
        chk_en <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic clear_acc();
        axil_resp_t resp;
        axil_write(REG_CTRL, 32'h1, resp);
        cleared       = 1'b1;
        model_acc     = '0;
        model_count   = '0;
        saw_ready_low = 1'b0;
    endtask

    task automatic finish_and_wait();
        axil_resp_t resp;
        acc_data_t status;
        axil_write(REG_CTRL, 32'h2, resp);
        do axil_read(REG_STATUS, status, resp); while (!status[1]);
    endtask

    // Factor first, then addend, when both land on the same edge
    task automatic fold_accepted();
        if (!ready_o) begin
            saw_ready_low = 1'b1;
        end
        if (mul_valid_i && ready_o) begin
            model_acc = model_acc * mul_data_i;
        end
        if (add_valid_i && ready_o) begin
            model_acc   = model_acc + add_data_i;
            model_count = model_count + 1;
        end
    endtask

    task automatic stream_beats(input int n, input int add_pct, input int mul_pct);
        for (int i = 0; i < n; i++) begin
            add_valid_i <= ($urandom % 100) < add_pct;
            add_data_i  <= $urandom;
            mul_valid_i <= ($urandom % 100) < mul_pct;
            mul_data_i  <= $urandom | 32'h1;
            @(posedge clk_i);
            fold_accepted();
        end
        add_valid_i <= 1'b0;
        mul_valid_i <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        @(posedge clk_i);
        tests++;
        if (errors == test_err_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_err_start);
        end
    endtask

    initial begin
        acc_data_t rd;
        axil_resp_t resp;
        void'($urandom(44));
        {s_awvalid_i, s_wvalid_i, s_arvalid_i, add_valid_i, mul_valid_i} = '0;
        s_bready_i = 1'b1;
        s_rready_i = 1'b1;
        {s_awaddr_i, s_araddr_i} = '0;
        {s_wdata_i, add_data_i, mul_data_i} = '0;
        {model_acc, model_count, chk_exp, chk_act} = '0;
        {cleared, saw_ready_low, chk_en} = '0;
        errors = 0;
        checks = 0;
        tests  = 0;
        cycles = 0;
        rst_ni = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        begin_test("reset");
        axil_read(REG_STATUS, rd, resp);
        check_value(32'h0, rd);
        check_value(acc_data_t'(RESP_OKAY), acc_data_t'(resp));
        // Unmapped offset between CTRL and STATUS
        axil_read(4'h2, rd, resp);
        check_value(acc_data_t'(RESP_SLVERR), acc_data_t'(resp));
        check_value(32'h0, rd);
        axil_write(REG_RESULT, 32'h1234, resp);
        check_value(acc_data_t'(RESP_SLVERR), acc_data_t'(resp));
        end_test();

        begin_test("addends_only");
        clear_acc();
        stream_beats(20, 80, 0);
        finish_and_wait();
        axil_read(REG_RESULT, rd, resp);
        check_value(model_acc, rd);
        axil_read(REG_COUNT, rd, resp);
        check_value(model_count, rd);
        end_test();

        begin_test("random_mix");
        clear_acc();
        stream_beats(40, 60, 40);
        finish_and_wait();
        axil_read(REG_RESULT, rd, resp);
        check_value(model_acc, rd);
        axil_read(REG_COUNT, rd, resp);
        check_value(model_count, rd);
        end_test();

        begin_test("burst_backpressure");
        clear_acc();
        stream_beats(60, 100, 70);
        check_value(32'h1, acc_data_t'(saw_ready_low));
        finish_and_wait();
        axil_read(REG_RESULT, rd, resp);
        check_value(model_acc, rd);
        axil_read(REG_COUNT, rd, resp);
        check_value(model_count, rd);
        end_test();

        begin_test("clear_mid_run");
        clear_acc();
        stream_beats(15, 60, 30);
        clear_acc();
        axil_read(REG_STATUS, rd, resp);
        check_value(32'h1, rd);
        stream_beats(25, 60, 30);
        axil_read(REG_STATUS, rd, resp);
        check_value(32'h1, rd);
        finish_and_wait();
        axil_read(REG_RESULT, rd, resp);
        check_value(model_acc, rd);
        end_test();

        begin_test("empty_finish");
        clear_acc();
        finish_and_wait();
        axil_read(REG_STATUS, rd, resp);
        check_value(32'h2, rd);
        axil_read(REG_RESULT, rd, resp);
        check_value(32'h0, rd);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/acc_types_pkg.sv
hdl/acc_regs_pkg.sv
hdl/tagged_fifo.sv
hdl/rescale_mac_pipe.sv
hdl/partial_sum_sched.sv
hdl/acc_axil_regs.sv
hdl/rescale_acc_top.sv
verif/rescale_acc_tb.sv

/* Makefile */
# Verilator build and run of the rescaling accumulator testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module rescale_acc_tb -Mdir obj_dir
	./obj_dir/Vrescale_acc_tb > $(LOG) 2>&1 || echo "Simulation finished: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
